/* source/complex_pkg.sv */
package complex_pkg;

    localparam int n_constants = 3;
    localparam int cfg_addr_width = 5;

    // Instructions sit at program_base and the words right after it
    localparam logic [cfg_addr_width-1:0] program_base = 5'd8;
    localparam logic [cfg_addr_width-1:0] output_sel_addr = 5'd16;

    typedef struct packed {
        logic write;
        logic [cfg_addr_width-1:0] addr;
        logic [31:0] data;
    } cfg_write_t;

    typedef struct packed {
        logic [3:0] dest;
        logic [31:0] data;
        logic last;
    } reg_write_t;

    typedef struct packed {
        logic [31:0] data;
        logic last;
    } out_word_t;

    // A count of zero is treated as a single word
    typedef struct packed {
        logic [3:0] base;
        logic [3:0] count;
    } output_sel_t;

endpackage

/* source/core_pkg.sv */
package core_pkg;

    localparam int reg_count = 16;
    localparam int reg_addr_width = $clog2(reg_count);
    localparam int program_length = 8;
    localparam int program_addr_width = $clog2(program_length);

    // Codes 6 and 7 are not listed and behave as nop
    typedef enum logic [2:0] {
        op_nop = 3'd0,
        op_add = 3'd1,
        op_sub = 3'd2,
        op_mul = 3'd3,
        op_min = 3'd4,
        op_max = 3'd5
    } opcode_t;

    typedef struct packed {
        opcode_t opcode;
        logic [reg_addr_width-1:0] dest;
        logic [reg_addr_width-1:0] src_a;
        logic [reg_addr_width-1:0] src_b;
    } instruction_t;

endpackage

/* source/constant_regs.sv */
`timescale 1ns/100ps

module constant_regs (
    input logic core_clock,
    input logic rst_n,
    input complex_pkg::cfg_write_t cfg,
    output logic [complex_pkg::n_constants-1:0][31:0] constants,
    output core_pkg::instruction_t [core_pkg::program_length-1:0] program_words,
    output complex_pkg::output_sel_t output_sel,
    output logic constants_loaded
);

    import complex_pkg::*;
    import core_pkg::*;

    logic [n_constants-1:0] written;

    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            constants <= '0;
            program_words <= '0;
            output_sel <= '0;
            written <= '0;
        end else if (cfg.write) begin
            for (int i = 0; i < n_constants; i++) begin
                if (cfg.addr == cfg_addr_width'(i)) begin
                    constants[i] <= cfg.data;
                    written[i] <= 1'b1;
                end
            end
            for (int i = 0; i < program_length; i++) begin
                if (cfg.addr == program_base + cfg_addr_width'(i)) begin
                    program_words[i] <= instruction_t'(cfg.data[$bits(instruction_t)-1:0]);
                end
            end
            if (cfg.addr == output_sel_addr) begin
                output_sel <= output_sel_t'(cfg.data[$bits(output_sel_t)-1:0]);
            end
        end
    end

    // Sticky, so rewriting a constant later never drops the complex back
    assign constants_loaded = &written;

endmodule

/* source/input_merger.sv */
`timescale 1ns/100ps

module input_merger (
    input logic core_clock,
    input logic rst_n,
    input logic load,
    input logic [complex_pkg::n_constants-1:0][31:0] constants,
    input complex_pkg::reg_write_t in_data,
    input logic in_valid,
    output logic in_ready,
    output complex_pkg::reg_write_t rf_write,
    output logic rf_write_en,
    output logic load_done
);

    import complex_pkg::*;

    localparam int const_idx_width = $clog2(n_constants);

    typedef enum logic [1:0] {
        ph_idle,
        ph_constants,
        ph_stream
    } phase_t;

    phase_t phase;
    logic [const_idx_width-1:0] const_idx;

    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            phase <= ph_idle;
            const_idx <= '0;
        end else begin
            case (phase)
                ph_idle: begin
                    if (load) begin
                        phase <= ph_constants;
                        const_idx <= '0;
                    end
                end
                ph_constants: begin
                    const_idx <= const_idx + 1'b1;
                    if (const_idx == const_idx_width'(n_constants - 1)) begin
                        phase <= ph_stream;
                    end
                end
                ph_stream: begin
                    if (in_valid && in_data.last) begin
                        phase <= ph_idle;
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

    assign in_ready = (phase == ph_stream);

    // Constant k is always written to register k
    always_comb begin
        if (phase == ph_constants) begin
            rf_write = '{dest: 4'(const_idx), data: constants[const_idx], last: 1'b0};
            rf_write_en = 1'b1;
        end else begin
            rf_write = in_data;
            rf_write_en = in_ready && in_valid;
        end
    end

    assign load_done = in_ready && in_valid && in_data.last;

endmodule

/* source/compute_core.sv */
`timescale 1ns/100ps

module compute_core (
    input logic core_clock,
    input logic rst_n,
    input complex_pkg::reg_write_t rf_write,
    input logic rf_write_en,
    input core_pkg::instruction_t [core_pkg::program_length-1:0] program_words,
    input logic run,
    output logic core_done,
    input logic [core_pkg::reg_addr_width-1:0] read_addr,
    output logic [31:0] read_data
);

    import core_pkg::*;

    logic [31:0] rf [reg_count];
    logic active;
    logic [program_addr_width-1:0] pc;
    instruction_t instr;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic alu_write;

    assign instr = program_words[pc];
    assign op_a = rf[instr.src_a];
    assign op_b = rf[instr.src_b];

    always_comb begin
        alu_write = 1'b1;
        case (instr.opcode)
            op_add: alu_result = op_a + op_b;
            op_sub: alu_result = op_a - op_b;
            op_mul: alu_result = op_a * op_b;
            op_min: alu_result = (op_a < op_b) ? op_a : op_b;
            op_max: alu_result = (op_a > op_b) ? op_a : op_b;
            default: begin
                alu_result = op_a;
                alu_write = 1'b0;
            end
        endcase
    end

    // One instruction per cycle, so each result lands before the next read
    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            rf <= '{default: '0};
            active <= 1'b0;
            pc <= '0;
        end else begin
            if (rf_write_en) begin
                rf[rf_write.dest] <= rf_write.data;
            end
            if (active && alu_write) begin
                rf[instr.dest] <= alu_result;
            end
            if (run) begin
                active <= 1'b1;
                pc <= '0;
            end else if (active) begin
                pc <= pc + 1'b1;
                if (pc == program_addr_width'(program_length - 1)) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // High while the last instruction executes, eight cycles after run
    assign core_done = active && (pc == program_addr_width'(program_length - 1));

    assign read_data = rf[read_addr];

endmodule

/* source/result_mover.sv */
`timescale 1ns/100ps

module result_mover (
    input logic core_clock,
    input logic rst_n,
    input logic emit,
    input complex_pkg::output_sel_t output_sel,
    output logic [core_pkg::reg_addr_width-1:0] read_addr,
    input logic [31:0] read_data,
    output complex_pkg::out_word_t out_data,
    output logic out_valid,
    input logic out_ready,
    output logic done
);

    logic active;
    logic [3:0] remaining;
    logic load_word;

    // The holding stage refills when empty or when its word is taken
    assign load_word = active && (!out_valid || out_ready);

    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            active <= 1'b0;
            read_addr <= '0;
            remaining <= '0;
            out_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (emit) begin
                active <= 1'b1;
                read_addr <= output_sel.base;
                remaining <= (output_sel.count == '0) ? 4'd1 : output_sel.count;
            end
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
                if (out_data.last) begin
                    done <= 1'b1;
                end
            end
            if (load_word) begin
                out_valid <= 1'b1;
                read_addr <= read_addr + 1'b1;
                remaining <= remaining - 1'b1;
                if (remaining == 4'd1) begin
                    active <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge core_clock) begin
        if (load_word) begin
            out_data <= '{data: read_data, last: (remaining == 4'd1)};
        end
    end

endmodule

/* source/core_complex.sv */
`timescale 1ns/100ps

module core_complex (
    input logic core_clock,
    input logic rst_n,
    input complex_pkg::cfg_write_t cfg,
    input logic start,
    input complex_pkg::reg_write_t in_data,
    input logic in_valid,
    output logic in_ready,
    output complex_pkg::out_word_t out_data,
    output logic out_valid,
    input logic out_ready,
    output logic busy,
    output logic done
);

    import complex_pkg::*;
    import core_pkg::*;

    typedef enum logic [2:0] {
        wait_constants,
        idle,
        load,
        compute,
        unload
    } seq_state_t;

    seq_state_t state;

    logic [n_constants-1:0][31:0] constants;
    instruction_t [program_length-1:0] program_words;
    output_sel_t output_sel;
    logic constants_loaded;
    reg_write_t rf_write;
    logic rf_write_en;
    logic load_start;
    logic load_done;
    logic run;
    logic core_done;
    logic emit;
    logic [reg_addr_width-1:0] read_addr;
    logic [31:0] read_data;

    constant_regs u_constant_regs (
        .core_clock(core_clock),
        .rst_n(rst_n),
        .cfg(cfg),
        .constants(constants),
        .program_words(program_words),
        .output_sel(output_sel),
        .constants_loaded(constants_loaded)
    );

    input_merger u_input_merger (
        .core_clock(core_clock),
        .rst_n(rst_n),
        .load(load_start),
        .constants(constants),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .rf_write(rf_write),
        .rf_write_en(rf_write_en),
        .load_done(load_done)
    );

    compute_core u_compute_core (
        .core_clock(core_clock),
        .rst_n(rst_n),
        .rf_write(rf_write),
        .rf_write_en(rf_write_en),
        .program_words(program_words),
        .run(run),
        .core_done(core_done),
        .read_addr(read_addr),
        .read_data(read_data)
    );

    result_mover u_result_mover (
        .core_clock(core_clock),
        .rst_n(rst_n),
        .emit(emit),
        .output_sel(output_sel),
        .read_addr(read_addr),
        .read_data(read_data),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .done(done)
    );

    // A start outside idle is simply not looked at
    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            state <= wait_constants;
            load_start <= 1'b0;
            run <= 1'b0;
            emit <= 1'b0;
        end else begin
            load_start <= 1'b0;
            run <= 1'b0;
            emit <= 1'b0;
            case (state)
                wait_constants: if (constants_loaded) state <= idle;
                idle: begin
                    if (start) begin
                        state <= load;
                        load_start <= 1'b1;
                    end
                end
                load: begin
                    if (load_done) begin
                        state <= compute;
                        run <= 1'b1;
                    end
                end
                compute: begin
                    if (core_done) begin
                        state <= unload;
                        emit <= 1'b1;
                    end
                end
                unload: if (done) state <= idle;
                default: state <= wait_constants;
            endcase
        end
    end

    assign busy = (state == load) || (state == compute) || (state == unload);

endmodule

/* tests/core_complex_assert.sv */
`timescale 1ns/100ps

module core_complex_assert (
    input logic core_clock,
    input logic rst_n,
    input logic in_ready,
    input complex_pkg::out_word_t out_data,
    input logic out_valid,
    input logic out_ready,
    input logic busy,
    input logic done,
    input logic run,
    input logic emit
);

    // An offered output word waits unchanged until it is taken
    assert property (@(posedge core_clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("out_valid dropped or out_data changed while out_ready was low");

    assert property (@(posedge core_clock) disable iff (!rst_n)
        done |=> !done)
        else $error("done lasted longer than one cycle");

    assert property (@(posedge core_clock) disable iff (!rst_n)
        !busy |-> !in_ready)
        else $error("in_ready was high while the complex was not busy");

    assert property (@(posedge core_clock)
        !rst_n |=> !busy && !done && !in_ready && !out_valid && !run && !emit)
        else $error("a control output was high in the cycle after reset");

endmodule

bind core_complex core_complex_assert u_core_complex_assert (.*);

/* tests/core_complex_tb.sv */
`timescale 1ns/100ps

module core_complex_tb;

    import complex_pkg::*;
    import core_pkg::*;

    localparam int timeout_cycles = 200;
    localparam int run_count = 8;

    logic core_clock;
    logic rst_n;
    cfg_write_t cfg;
    logic start;
    reg_write_t in_data;
    logic in_valid;
    logic in_ready;
    out_word_t out_data;
    logic out_valid;
    logic out_ready;
    logic busy;
    logic done;

    // Reference copy of the configuration and of the register file
    logic [31:0] model_const [n_constants];
    instruction_t model_prog [program_length];
    output_sel_t model_sel;
    logic [31:0] model_rf [reg_count];
    reg_write_t inputs [$];
    out_word_t expected_words [$];
    int done_count = 0;

    core_complex uut (
        .core_clock(core_clock),
        .rst_n(rst_n),
        .cfg(cfg),
        .start(start),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .busy(busy),
        .done(done)
    );

    initial begin
        core_clock = 1'b0;
        forever #50 core_clock = ~core_clock;
    end

    always @(negedge core_clock) begin
        if (rst_n && done) begin
            done_count++;
        end
    end

    task automatic next_cycle();
        @(posedge core_clock);
        #10;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input out_word_t expected, input out_word_t actual, input int index);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %0d ns: word %0d is %h last %b, expected %h last %b",
                $time, index, actual.data, actual.last, expected.data, expected.last));
        end
    endtask

    task automatic check_done(input int expected, input int actual);
        if (actual != expected) begin
            abort_run($sformatf("[ERROR] %0d ns: %0d done pulses seen, expected %0d",
                $time, actual, expected));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %0d ns: %s is %b, expected %b",
                $time, name, actual, expected));
        end
    endtask

    task automatic write_cfg(input logic [cfg_addr_width-1:0] addr, input logic [31:0] data);
        cfg = '{write: 1'b1, addr: addr, data: data};
        next_cycle();
        cfg.write = 1'b0;
    endtask

    task automatic set_constant(input int k, input logic [31:0] value);
        write_cfg(cfg_addr_width'(k), value);
        model_const[k] = value;
    endtask

    // Rotating the codes puts every opcode, the unlisted ones too, in each program
    task automatic set_program(input int offset);
        instruction_t instr;
        for (int i = 0; i < program_length; i++) begin
            instr.opcode = opcode_t'(3'((i + offset) % 8));
            instr.dest = 4'($urandom);
            instr.src_a = 4'($urandom);
            instr.src_b = 4'($urandom);
            write_cfg(program_base + cfg_addr_width'(i), 32'(instr));
            model_prog[i] = instr;
        end
    endtask

    task automatic set_output_sel(input logic [3:0] base, input logic [3:0] count);
        write_cfg(output_sel_addr, {24'd0, base, count});
        model_sel.base = base;
        model_sel.count = count;
    endtask

    // The first word always hits a constant register
    task automatic make_inputs();
        int n;
        reg_write_t word;
        inputs.delete();
        n = 1 + int'($urandom % 5);
        for (int i = 0; i < n; i++) begin
            word.dest = (i == 0) ? 4'($urandom % 3) : 4'($urandom);
            word.data = $urandom;
            word.last = (i == n - 1);
            inputs.push_back(word);
        end
    endtask

    task automatic apply_model();
        logic [31:0] a;
        logic [31:0] b;
        int count;
        out_word_t word;
        expected_words.delete();
        for (int k = 0; k < n_constants; k++) begin
            model_rf[k] = model_const[k];
        end
        foreach (inputs[i]) begin
            model_rf[inputs[i].dest] = inputs[i].data;
        end
        foreach (model_prog[i]) begin
            a = model_rf[model_prog[i].src_a];
            b = model_rf[model_prog[i].src_b];
            case (model_prog[i].opcode)
                op_add: model_rf[model_prog[i].dest] = a + b;
                op_sub: model_rf[model_prog[i].dest] = a - b;
                op_mul: model_rf[model_prog[i].dest] = a * b;
                op_min: model_rf[model_prog[i].dest] = (a < b) ? a : b;
                op_max: model_rf[model_prog[i].dest] = (a > b) ? a : b;
                default: ;
            endcase
        end
        count = (model_sel.count == 4'd0) ? 1 : int'(model_sel.count);
        for (int j = 0; j < count; j++) begin
            word.data = model_rf[(int'(model_sel.base) + j) % reg_count];
            word.last = (j == count - 1);
            expected_words.push_back(word);
        end
    endtask

    task automatic run_once();
        int wait_count;
        int done_before;
        int index;
        apply_model();
        done_before = done_count;
        start = 1'b1;
        wait_count = 0;
        while (!busy) begin
            next_cycle();
            wait_count++;
            if (wait_count > timeout_cycles) abort_run("Timed out waiting for busy after start");
        end
        // Extra starts while busy must not queue a second run
        foreach (inputs[i]) begin
            in_valid = 1'b0;
            repeat ($urandom % 3) begin
                start = 1'($urandom);
                next_cycle();
            end
            in_valid = 1'b1;
            in_data = inputs[i];
            wait_count = 0;
            while (!in_ready) begin
                start = 1'($urandom);
                next_cycle();
                wait_count++;
                if (wait_count > timeout_cycles) abort_run("Timed out waiting for in_ready");
            end
            next_cycle();
        end
        in_valid = 1'b0;
        start = 1'b0;
        index = 0;
        wait_count = 0;
        while (index < expected_words.size()) begin
            out_ready = 1'($urandom);
            if (out_valid && out_ready) begin
                check_word(expected_words[index], out_data, index);
                index++;
                wait_count = 0;
            end
            next_cycle();
            wait_count++;
            if (wait_count > timeout_cycles) abort_run("Timed out waiting for an output word");
        end
        out_ready = 1'b0;
        repeat (3) begin
            next_cycle();
            check_flag("out_valid after the final word", 1'b0, out_valid);
        end
        check_flag("busy after the run", 1'b0, busy);
        check_done(done_before + 1, done_count);
    endtask

    initial begin
        void'($urandom(32'hfe44d6ff));
        rst_n = 1'b0;
        cfg = '0;
        start = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        model_sel = '0;
        foreach (model_rf[i]) model_rf[i] = '0;
        foreach (model_const[i]) model_const[i] = '0;
        foreach (model_prog[i]) model_prog[i] = '0;
        repeat (4) @(posedge core_clock);
        #10;
        rst_n = 1'b1;

        // With constant 2 still unwritten the complex stays in its wait state
        set_constant(0, $urandom);
        set_constant(1, $urandom);
        set_program(int'($urandom % 8));
        set_output_sel(4'd0, 4'd4);
        start = 1'b1;
        repeat (6) begin
            next_cycle();
            check_flag("busy before all constants are written", 1'b0, busy);
        end
        start = 1'b0;
        check_done(0, done_count);
        set_constant(2, $urandom);
        make_inputs();
        run_once();

        for (int run_index = 1; run_index < run_count; run_index++) begin
            if (run_index % 3 == 0) begin
                for (int k = 0; k < n_constants; k++) begin
                    set_constant(k, $urandom);
                end
            end
            set_program(int'($urandom % 8));
            case (run_index)
                1: set_output_sel(4'd14, 4'd5);
                2: set_output_sel(4'($urandom), 4'd0);
                default: set_output_sel(4'($urandom), 4'($urandom));
            endcase
            make_inputs();
            run_once();
        end

        $display("TEST OK");
        $finish;
    end

endmodule

/* sources.f */
source/complex_pkg.sv
source/core_pkg.sv
source/constant_regs.sv
source/input_merger.sv
source/compute_core.sv
source/result_mover.sv
source/core_complex.sv
tests/core_complex_assert.sv
tests/core_complex_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module core_complex_tb \
		-f sources.f -Mdir obj_dir -o core_complex_sim
	./obj_dir/core_complex_sim | tee sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
